//--- mfu_macros.svh
`ifndef MFU_MACROS_SVH
`define MFU_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define OPND_W 8
`define PROD_W 16
`define ACC_W  24

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Saturation limits of the signed accumulator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Largest positive value, 0111...1.
`define ACC_MAX {1'b0, {(`ACC_W-1){1'b1}}}
// Most negative value, 1000...0.
`define ACC_MIN {1'b1, {(`ACC_W-1){1'b0}}}

`endif

//--- mfu_pkg.sv
package mfu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Precision mode of the fusion unit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        MODE_8X8  = 2'b00,  // One signed 8x8 product.
        MODE_4X4  = 2'b01,  // Two nibble lanes, summed.
        MODE_2X2  = 2'b10,  // Four 2-bit lanes, summed.
        MODE_NOOP = 2'b11   // Empty slot.
    } prec_mode_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Accumulate opcode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic {
        ACC_LOAD = 1'b0,    // Replace accumulator with product.
        ACC_MAC  = 1'b1     // Add product to accumulator.
    } acc_op_t;

endpackage

//--- mbb.sv
`timescale 1ns/1ps

module mbb (
    input  logic       en,
    input  logic [1:0] a,
    input  logic [1:0] b,
    input  logic [1:0] sel,
    output logic [3:0] p
);

    // sel[1] marks a as signed, sel[0] marks b as signed.
    logic signed [2:0] a_ext;
    logic signed [2:0] b_ext;
    logic signed [5:0] full;

    // A signed field extends its top bit, an unsigned one gets a zero.
    assign a_ext = {sel[1] & a[1], a};
    assign b_ext = {sel[0] & b[1], b};

    assign full = a_ext * b_ext;

    // Every brick result fits in 4 bits. Signed ones range -6..4,
    // unsigned ones 0..9.
    assign p = en ? full[3:0] : 4'b0000;

endmodule

//--- mfu.sv
`timescale 1ns/1ps
`include "mfu_macros.svh"

module mfu (
    input  logic                clk,
    input  logic                nrst,
    input  logic [`OPND_W-1:0]  a,
    input  logic [`OPND_W-1:0]  b,
    input  mfu_pkg::prec_mode_t mode,
    output logic [`PROD_W-1:0]  p
);

    import mfu_pkg::*;

    logic [15:0] en;
    logic [31:0] sel;
    logic [3:0]  pp [16];
    logic [7:0]  sub [4];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Mode decode into brick enables and signedness selects.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (mode)
            MODE_8X8: begin
                en  = 16'b1111_1111_1111_1111;
                sel = 32'b11100100_10100000_01000100_00000000;
            end
            MODE_4X4: begin
                en  = 16'b1111_0000_0000_1111;
                sel = 32'b11100100_00000000_00000000_11100100;
            end
            MODE_2X2: begin
                en  = 16'b1001_0000_0000_1001;
                sel = 32'b11000011_00000000_00000000_11000011;
            end
            default: begin
                en  = 16'b0;
                sel = 32'b0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Brick array. Index bits {a_nib, b_nib, a_hi, b_hi}.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < 16; i++) begin : g_brick
        localparam int AOFF = 4 * ((i >> 3) & 1) + 2 * ((i >> 1) & 1);
        localparam int BOFF = 4 * ((i >> 2) & 1) + 2 * (i & 1);

        mbb mbb_i (
            .en  (en[i]),
            .a   (a[AOFF +: 2]),
            .b   (b[BOFF +: 2]),
            .sel (sel[2*i +: 2]),
            .p   (pp[i])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Four 4x4 subproducts. sub[3] is high x high, sub[0] low x low.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < 4; g++) begin : g_sub
        logic       hl_ext;
        logic       lh_ext;
        logic [5:0] mid;

        // Cross terms extend only when the brick had a signed operand.
        assign hl_ext = pp[4*g+2][3] & (|sel[2*(4*g+2) +: 2]);
        assign lh_ext = pp[4*g+1][3] & (|sel[2*(4*g+1) +: 2]);

        assign mid    = {{2{hl_ext}}, pp[4*g+2]} + {{2{lh_ext}}, pp[4*g+1]};
        assign sub[g] = {pp[4*g+3], pp[4*g]} + {mid, 2'b00};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Final combine per mode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (!nrst) begin
            p = '0;
        end else begin
            case (mode)
                MODE_8X8: p = {sub[3], sub[0]}
                            + {{{4{sub[2][7]}}, sub[2]} + {{4{sub[1][7]}}, sub[1]}, 4'b0000};
                MODE_4X4: p = {{(`PROD_W-8){sub[3][7]}}, sub[3]}
                            + {{(`PROD_W-8){sub[0][7]}}, sub[0]};
                // Lanes are bricks 15, 12, 3 and 0, each with its own sign.
                MODE_2X2: p = {{(`PROD_W-4){pp[15][3]}}, pp[15]}
                            + {{(`PROD_W-4){pp[12][3]}}, pp[12]}
                            + {{(`PROD_W-4){pp[3][3]}}, pp[3]}
                            + {{(`PROD_W-4){pp[0][3]}}, pp[0]};
                default:  p = '0;
            endcase
        end
    end

    // Full brick tree against a direct signed multiply.
    a_prod_8x8 : assert property (@(posedge clk) disable iff (!nrst)
        (mode == MODE_8X8) |-> ($signed(p) == $signed(a) * $signed(b)))
        else $error("mfu 8x8 product mismatch p=%h a=%h b=%h", p, a, b);

endmodule

//--- mul_stage.sv
`timescale 1ns/1ps
`include "mfu_macros.svh"

module mul_stage (
    input  logic                clk,
    input  logic                nrst,
    input  logic                in_valid,
    input  logic [`OPND_W-1:0]  a,
    input  logic [`OPND_W-1:0]  b,
    input  mfu_pkg::prec_mode_t mode,
    input  mfu_pkg::acc_op_t    op,
    output logic                prod_valid,
    output logic [`PROD_W-1:0]  prod,
    output mfu_pkg::acc_op_t    prod_op
);

    import mfu_pkg::*;

    logic [`PROD_W-1:0] p;
    logic               take;

    mfu mfu_i (
        .clk  (clk),
        .nrst (nrst),
        .a    (a),
        .b    (b),
        .mode (mode),
        .p    (p)
    );

    assign take = in_valid && (mode != MODE_NOOP);    // NOOP slots are dropped.

    always_ff @(posedge clk) begin
        if (!nrst) begin
            prod_valid <= 1'b0;
            prod       <= '0;
            prod_op    <= ACC_LOAD;
        end else begin
            prod_valid <= take;
            if (take) begin
                prod    <= p;
                prod_op <= op;
            end
        end
    end

    a_noop_drop : assert property (@(posedge clk) disable iff (!nrst)
        (mode == MODE_NOOP) |=> !prod_valid)
        else $error("mul_stage raised prod_valid after a NOOP slot");

endmodule

//--- acc_stage.sv
`timescale 1ns/1ps
`include "mfu_macros.svh"

module acc_stage (
    input  logic               clk,
    input  logic               nrst,
    input  logic               prod_valid,
    input  logic [`PROD_W-1:0] prod,
    input  mfu_pkg::acc_op_t   prod_op,
    output logic               out_valid,
    output logic [`ACC_W-1:0]  acc,
    output logic               overflow
);

    import mfu_pkg::*;

    logic [`ACC_W-1:0] prod_ext;
    logic [`ACC_W:0]   sum;     // One guard bit.
    logic              pos_ovf;
    logic              neg_ovf;

    assign prod_ext = {{(`ACC_W-`PROD_W){prod[`PROD_W-1]}}, prod};
    assign sum      = {acc[`ACC_W-1], acc} + {prod_ext[`ACC_W-1], prod_ext};

    // Guard and sign bits disagree on overflow.
    assign pos_ovf = !sum[`ACC_W] && sum[`ACC_W-1];
    assign neg_ovf = sum[`ACC_W] && !sum[`ACC_W-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Accumulator with saturation and sticky overflow.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!nrst) begin
            out_valid <= 1'b0;
            acc       <= '0;
            overflow  <= 1'b0;
        end else begin
            out_valid <= prod_valid;
            if (prod_valid) begin
                if (prod_op == ACC_LOAD) begin
                    acc      <= prod_ext;
                    overflow <= 1'b0;
                end else if (pos_ovf) begin
                    acc      <= `ACC_MAX;   // Clamp high.
                    overflow <= 1'b1;
                end else if (neg_ovf) begin
                    acc      <= `ACC_MIN;   // Clamp low.
                    overflow <= 1'b1;
                end else begin
                    acc <= sum[`ACC_W-1:0];
                end
            end
        end
    end

    // Overflow only rises on a MAC that clamped to a limit.
    a_ovf_mac : assert property (@(posedge clk) disable iff (!nrst)
        $rose(overflow) |->
            $past(prod_valid && prod_op == ACC_MAC)
            && (acc == `ACC_MAX || acc == `ACC_MIN))
        else $error("acc_stage overflow rose without a clamping MAC, acc=%h", acc);

endmodule

//--- mac_top.sv
`timescale 1ns/1ps
`include "mfu_macros.svh"

module mac_top (
    input  logic                clk,
    input  logic                nrst,
    input  logic                in_valid,
    input  logic [`OPND_W-1:0]  a,
    input  logic [`OPND_W-1:0]  b,
    input  mfu_pkg::prec_mode_t mode,
    input  mfu_pkg::acc_op_t    op,
    output logic                out_valid,
    output logic [`ACC_W-1:0]   acc,
    output logic                overflow
);

    import mfu_pkg::*;

    // Stage 1 to stage 2.
    logic               prod_valid;
    logic [`PROD_W-1:0] prod;
    acc_op_t            prod_op;

    mul_stage mul_stage_i (
        .clk        (clk),
        .nrst       (nrst),
        .in_valid   (in_valid),
        .a          (a),
        .b          (b),
        .mode       (mode),
        .op         (op),
        .prod_valid (prod_valid),
        .prod       (prod),
        .prod_op    (prod_op)
    );

    acc_stage acc_stage_i (
        .clk        (clk),
        .nrst       (nrst),
        .prod_valid (prod_valid),
        .prod       (prod),
        .prod_op    (prod_op),
        .out_valid  (out_valid),
        .acc        (acc),
        .overflow   (overflow)
    );

endmodule

//--- tb_mac_top.sv
`timescale 1ns/1ps
`include "mfu_macros.svh"

module tb_mac_top;

    import mfu_pkg::*;

    localparam int ACC_HI      = 2 ** (`ACC_W - 1) - 1;
    localparam int ACC_LO      = -(2 ** (`ACC_W - 1));
    localparam int DRAIN_LIMIT = 20;

    logic               clk = 1'b0;
    logic               nrst;
    logic               in_valid;
    logic [`OPND_W-1:0] a;
    logic [`OPND_W-1:0] b;
    prec_mode_t         mode;
    acc_op_t            op;
    logic               out_valid;
    logic [`ACC_W-1:0]  acc;
    logic               overflow;

    // Reference pipeline, one register per DUT stage.
    logic               m_valid;
    logic [`PROD_W-1:0] m_prod;
    acc_op_t            m_op;
    logic               exp_valid;
    logic [`ACC_W-1:0]  exp_acc;
    logic               exp_ovf;
    int                 prod_new;
    int                 prod_i;
    int                 sum_i;

    logic [31:0] lfsr      = 32'h25df83f6;
    logic        armed     = 1'b0;  // Outputs are known once reset has been seen.
    int          issued    = 0;
    int          retired   = 0;
    int          errors    = 0;
    int          err_mark  = 0;
    int          test_num  = 0;
    int          tests_bad = 0;

    initial begin
        forever #50 clk = ~clk;
    end

    mac_top mac_top_i (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .mode      (mode),
        .op        (op),
        .out_valid (out_valid),
        .acc       (acc),
        .overflow  (overflow)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus source and lane arithmetic.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic lfsr_step();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ 32'h80200003;   // x^32 + x^22 + x^2 + x + 1.
        return lsb;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[6:0], lfsr_step()};
        return r;
    endfunction

    // Two's complement value of the low w bits of v.
    function automatic int sign_extend(input logic [7:0] v, input int w);
        int r;
        r = {24'b0, v} & ((1 << w) - 1);
        if (v[w-1])
            r = r - (1 << w);
        return r;
    endfunction

    function automatic int ref_product(input logic [7:0] x, input logic [7:0] y,
                                       input prec_mode_t m);
        int s;
        s = 0;
        case (m)
            MODE_8X8: s = sign_extend(x, 8) * sign_extend(y, 8);
            MODE_4X4: begin
                for (int k = 0; k < 2; k++)
                    s = s + sign_extend(x >> (4 * k), 4) * sign_extend(y >> (4 * k), 4);
            end
            MODE_2X2: begin
                for (int k = 0; k < 4; k++)
                    s = s + sign_extend(x >> (2 * k), 2) * sign_extend(y >> (2 * k), 2);
            end
            default: s = 0;
        endcase
        return s;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model, two cycles from input to result.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!nrst) begin
            m_valid   <= 1'b0;
            m_prod    <= '0;
            m_op      <= ACC_LOAD;
            exp_valid <= 1'b0;
            exp_acc   <= '0;
            exp_ovf   <= 1'b0;
            retired   <= 0;
        end else begin
            if (out_valid)
                retired <= retired + 1;
            m_valid <= in_valid && mode != MODE_NOOP;
            if (in_valid && mode != MODE_NOOP) begin
                prod_new = ref_product(a, b, mode);
                m_prod <= prod_new[`PROD_W-1:0];
                m_op   <= op;
            end
            exp_valid <= m_valid;
            if (m_valid) begin
                prod_i = {{(32-`PROD_W){m_prod[`PROD_W-1]}}, m_prod};
                sum_i  = {{(32-`ACC_W){exp_acc[`ACC_W-1]}}, exp_acc} + prod_i;
                if (m_op == ACC_LOAD) begin
                    exp_acc <= prod_i[`ACC_W-1:0];
                    exp_ovf <= 1'b0;
                end else if (sum_i > ACC_HI) begin
                    exp_acc <= `ACC_MAX;
                    exp_ovf <= 1'b1;
                end else if (sum_i < ACC_LO) begin
                    exp_acc <= `ACC_MIN;
                    exp_ovf <= 1'b1;
                end else begin
                    exp_acc <= sum_i[`ACC_W-1:0];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_idle : assert property (@(posedge clk) disable iff (!armed)
        !nrst |=> (!out_valid && !overflow && acc == '0))
        else begin
            errors++;
            $display("Error: outputs not idle in reset, out_valid=%h overflow=%h acc=%h",
                     $sampled(out_valid), $sampled(overflow), $sampled(acc));
        end

    a_valid_match : assert property (@(posedge clk) disable iff (!armed)
        out_valid == exp_valid)
        else begin
            errors++;
            $display("Error: out_valid expected %h got %h",
                     $sampled(exp_valid), $sampled(out_valid));
        end

    a_acc_match : assert property (@(posedge clk) disable iff (!armed)
        acc == exp_acc)
        else begin
            errors++;
            $display("Error: acc expected %h got %h", $sampled(exp_acc), $sampled(acc));
        end

    a_ovf_match : assert property (@(posedge clk) disable iff (!armed)
        overflow == exp_ovf)
        else begin
            errors++;
            $display("Error: overflow expected %h got %h",
                     $sampled(exp_ovf), $sampled(overflow));
        end

    // An empty or NOOP slot retires nothing two edges later.
    a_idle_slot : assert property (@(posedge clk) disable iff (!nrst || !armed)
        !(in_valid && mode != MODE_NOOP) |-> ##2 (!out_valid && $stable(acc)))
        else begin
            errors++;
            $display("Error: empty slot raised out_valid or moved acc, out_valid=%h acc=%h",
                     $sampled(out_valid), $sampled(acc));
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_item(input logic v, input logic [7:0] x, input logic [7:0] y,
                              input prec_mode_t m, input acc_op_t o);
        @(posedge clk);
        in_valid <= v;
        a        <= x;
        b        <= y;
        mode     <= m;
        op       <= o;
        if (v && m != MODE_NOOP)
            issued++;
    endtask

    task automatic send_random(input prec_mode_t m, input acc_op_t o);
        logic [7:0] x;
        logic [7:0] y;
        x = rand_bits(8);
        y = rand_bits(8);
        drive_item(1'b1, x, y, m, o);
    endtask

    // Waits for every issued item to retire, then reports the test.
    task automatic finish_test(input string name);
        int t;
        t = 0;
        drive_item(1'b0, 8'h00, 8'h00, MODE_NOOP, ACC_LOAD);
        while (retired != issued && t < DRAIN_LIMIT) begin
            @(posedge clk);
            t++;
        end
        @(negedge clk);
        test_num++;
        if (retired != issued) begin
            errors++;
            tests_bad++;
            $display("test %0d %s: timed out with %0d of %0d items retired", test_num, name,
                     retired, issued);
        end else if (errors == err_mark) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAILED with %0d errors", test_num, name,
                     errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        @(posedge clk);
        @(negedge clk);
        armed = 1'b1;
    end

    initial begin
        logic [7:0] corner [3];
        logic [7:0] r;
        prec_mode_t m;

        corner = '{8'h80, 8'h7f, 8'h00};
        nrst     <= 1'b0;
        in_valid <= 1'b0;
        a        <= '0;
        b        <= '0;
        mode     <= MODE_NOOP;
        op       <= ACC_LOAD;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        finish_test("reset");

        for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
                drive_item(1'b1, corner[i], corner[j], MODE_8X8, ACC_LOAD);
        repeat (24) send_random(MODE_8X8, ACC_LOAD);
        finish_test("8x8 load");

        drive_item(1'b1, 8'h88, 8'h88, MODE_4X4, ACC_LOAD);
        drive_item(1'b1, 8'h77, 8'h88, MODE_4X4, ACC_LOAD);
        repeat (24) send_random(MODE_4X4, ACC_LOAD);
        finish_test("4x4 load");

        drive_item(1'b1, 8'haa, 8'haa, MODE_2X2, ACC_LOAD);
        drive_item(1'b1, 8'h55, 8'haa, MODE_2X2, ACC_LOAD);
        repeat (24) send_random(MODE_2X2, ACC_LOAD);
        finish_test("2x2 load");

        send_random(MODE_8X8, ACC_LOAD);
        for (int i = 0; i < 16; i++) begin
            r = rand_bits(2);
            m = prec_mode_t'(r[1:0]);
            send_random(m, ACC_MAC);
        end
        // 512 products of 16384 pass the positive limit.
        drive_item(1'b1, 8'h80, 8'h80, MODE_8X8, ACC_LOAD);
        repeat (519) drive_item(1'b1, 8'h80, 8'h80, MODE_8X8, ACC_MAC);
        send_random(MODE_4X4, ACC_LOAD);
        drive_item(1'b1, 8'h80, 8'h7f, MODE_8X8, ACC_LOAD);
        repeat (520) drive_item(1'b1, 8'h80, 8'h7f, MODE_8X8, ACC_MAC);
        send_random(MODE_2X2, ACC_LOAD);
        finish_test("mac and saturation");

        for (int i = 0; i < 40; i++) begin
            r = rand_bits(2);
            m = prec_mode_t'(r[1:0]);
            r = rand_bits(2);
            if (i % 5 == 0)
                drive_item(1'b1, rand_bits(8), rand_bits(8), MODE_NOOP, ACC_LOAD);
            else
                drive_item(r[0], rand_bits(8), rand_bits(8), m, acc_op_t'(r[1]));
        end
        finish_test("idle and noop slots");

        $display("tests %0d, failed %0d, errors %0d", test_num, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
mfu_pkg.sv
mbb.sv
mfu.sv
mul_stage.sv
acc_stage.sv
mac_top.sv
tb_mac_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mac_top
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
